/* common/stream_pkg.sv */
////////////////////
// widths, pipeline latency and word types
// shared by the pattern generator blocks
////////////////////

package stream_pkg;

    // a pattern word is as wide as a stream word.
    localparam int unsigned NB_DATA = 32;

    // pattern memory address width for 64 words.
    localparam int unsigned NB_ADDR = 6;

    // width of the pass counter.
    localparam int unsigned NB_PASS = 8;

    // read stages between address issue and the output register.
    // the memory read register is the first, the output register the second.
    localparam int unsigned DPATH_LATENCY = 2;

    // one memory or stream word.
    typedef logic [NB_DATA-1:0] data_t;

    // one memory address.
    typedef logic [NB_ADDR-1:0] addr_t;

    // a pass count.
    typedef logic [NB_PASS-1:0] pass_t;

    // running checksum as wide as a word.
    typedef logic [NB_DATA-1:0] chk_t;

endpackage

/* logic/pattern_bram.sv */
////////////////////
// pattern memory, one write port
////////////////////

`timescale 1ns/1ps

module pattern_bram
    import stream_pkg::*;
(
    input  logic  i_clk,

    input  logic  i_wr_enb,
    input  addr_t i_wr_addr,
    input  data_t i_wr_data,

    input  logic  i_rd_enb,
    input  addr_t i_rd_addr,
    output data_t o_rd_data
);

    data_t mem [2**NB_ADDR];
    data_t rd_data;

    always_ff @(posedge i_clk) begin
        if (i_wr_enb) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // the read register holds its word while the enable is low.
    always_ff @(posedge i_clk) begin
        if (i_rd_enb) begin
            rd_data <= mem[i_rd_addr];
        end
    end

    assign o_rd_data = rd_data;

endmodule

/* producer/axis_producer.sv */
////////////////////
// windowed memory reader
// driving the output stream
////////////////////

`timescale 1ns/1ps

module axis_producer
    import stream_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst,

    input  logic  i_restart,
    input  logic  i_run,
    input  addr_t i_win_start,
    input  addr_t i_win_end,

    output logic  o_mem_rd_enb,
    output addr_t o_mem_rd_addr,
    input  data_t i_mem_rd_data,

    input  logic  i_axis_ready,
    output logic  o_axis_valid,
    output data_t o_axis_data,
    output logic  o_axis_last
);

    addr_t                    rd_addr;
    logic                     advance;
    logic                     out_vld;
    logic [DPATH_LATENCY-1:0] vld_sr;
    logic [DPATH_LATENCY-1:0] last_sr;
    data_t                    axis_data;

    assign out_vld = vld_sr[DPATH_LATENCY-1];

    // the whole pipeline moves as one.
    // it moves when the output word leaves, or while the output stage is empty.
    assign advance = i_run & ~i_restart & (~out_vld | i_axis_ready);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rd_addr <= '0;
        end
        else if (i_restart) begin
            rd_addr <= i_win_start;
        end
        else if (advance) begin
            if (rd_addr == i_win_end) begin
                rd_addr <= i_win_start;
            end
            else begin
                rd_addr <= rd_addr + addr_t'(1);
            end
        end
    end

    // words still in flight are dropped once run falls.
    always_ff @(posedge i_clk) begin
        if (i_rst || i_restart || !i_run) begin
            vld_sr <= '0;
        end
        else if (advance) begin
            vld_sr <= {vld_sr[DPATH_LATENCY-2:0], 1'b1};
        end
    end

    // the end-address mark follows its word through both stages.
    always_ff @(posedge i_clk) begin
        if (i_rst || i_restart) begin
            last_sr <= '0;
        end
        else if (advance) begin
            last_sr <= {last_sr[DPATH_LATENCY-2:0], rd_addr == i_win_end};
        end
    end

    always_ff @(posedge i_clk) begin
        if (advance) begin
            axis_data <= i_mem_rd_data;
        end
    end

    assign o_mem_rd_enb  = advance;
    assign o_mem_rd_addr = rd_addr;

    // run falls in the cycle after the final transfer, so it masks the next word.
    assign o_axis_valid = out_vld & i_run;
    assign o_axis_data  = axis_data;
    assign o_axis_last  = last_sr[DPATH_LATENCY-1];

endmodule

/* logic/stream_ctrl.sv */
////////////////////
// run control, loads, passes, busy and done
////////////////////

`timescale 1ns/1ps

module stream_ctrl
    import stream_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst,

    input  logic  i_start,
    input  addr_t i_start_addr,
    input  addr_t i_end_addr,
    input  pass_t i_pass_count,

    input  logic  i_load_valid,
    output logic  o_load_ready,
    output logic  o_mem_wr_enb,

    input  logic  i_xfer,
    input  logic  i_xfer_last,

    output logic  o_restart,
    output logic  o_run,
    output addr_t o_win_start,
    output addr_t o_win_end,
    output logic  o_busy,
    output logic  o_done
);

    logic  busy;
    logic  restart;
    logic  done;
    logic  start_ok;
    pass_t passes_left;
    addr_t win_start;
    addr_t win_end;

    // a start is taken only while idle and over a well-ordered window.
    assign start_ok = i_start & ~busy & (i_start_addr <= i_end_addr);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            busy        <= 1'b0;
            restart     <= 1'b0;
            done        <= 1'b0;
            passes_left <= '0;
        end
        else begin
            restart <= 1'b0;
            done    <= 1'b0;
            if (start_ok) begin
                restart <= 1'b1;
                if (i_pass_count == '0) begin
                    done <= 1'b1;
                end
                else begin
                    busy        <= 1'b1;
                    passes_left <= i_pass_count;
                end
            end
            else if (busy && i_xfer && i_xfer_last) begin
                // one pass ends with each word read from the end address.
                passes_left <= passes_left - pass_t'(1);
                if (passes_left == pass_t'(1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (start_ok) begin
            win_start <= i_start_addr;
            win_end   <= i_end_addr;
        end
    end

    assign o_load_ready = ~busy;
    assign o_mem_wr_enb = i_load_valid & ~busy;
    assign o_restart    = restart;
    assign o_run        = busy;
    assign o_win_start  = win_start;
    assign o_win_end    = win_end;
    assign o_busy       = busy;
    assign o_done       = done;

endmodule

/* logic/stream_checksum.sv */
////////////////////
// rotate-xor signature of stream words
////////////////////

`timescale 1ns/1ps

module stream_checksum
    import stream_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst,

    input  logic  i_restart,

    input  logic  i_axis_valid,
    input  logic  i_axis_ready,
    input  data_t i_axis_data,

    output chk_t  o_checksum
);

    chk_t checksum;
    chk_t rotated;

    assign rotated = {checksum[NB_DATA-2:0], checksum[NB_DATA-1]};

    always_ff @(posedge i_clk) begin
        if (i_rst || i_restart) begin
            checksum <= '0;
        end
        else if (i_axis_valid && i_axis_ready) begin
            // rotate left by one, then fold in the accepted word.
            checksum <= rotated ^ i_axis_data;
        end
    end

    assign o_checksum = checksum;

endmodule

/* logic/stream_gen_top.sv */
////////////////////
// pattern generator top level
////////////////////

`timescale 1ns/1ps

module stream_gen_top
    import stream_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst,

    input  logic  i_load_valid,
    input  addr_t i_load_addr,
    input  data_t i_load_data,
    output logic  o_load_ready,

    input  logic  i_start,
    input  addr_t i_start_addr,
    input  addr_t i_end_addr,
    input  pass_t i_pass_count,

    input  logic  i_axis_ready,
    output logic  o_axis_valid,
    output data_t o_axis_data,
    output logic  o_axis_last,

    output logic  o_busy,
    output logic  o_done,
    output chk_t  o_checksum
);

    logic  mem_wr_enb;
    logic  mem_rd_enb;
    addr_t mem_rd_addr;
    data_t mem_rd_data;
    logic  restart;
    logic  run;
    addr_t win_start;
    addr_t win_end;
    logic  xfer;

    // a transfer is the output handshake itself.
    assign xfer = o_axis_valid & i_axis_ready;

    stream_ctrl u_ctrl (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_start      (i_start),
        .i_start_addr (i_start_addr),
        .i_end_addr   (i_end_addr),
        .i_pass_count (i_pass_count),
        .i_load_valid (i_load_valid),
        .o_load_ready (o_load_ready),
        .o_mem_wr_enb (mem_wr_enb),
        .i_xfer       (xfer),
        .i_xfer_last  (o_axis_last),
        .o_restart    (restart),
        .o_run        (run),
        .o_win_start  (win_start),
        .o_win_end    (win_end),
        .o_busy       (o_busy),
        .o_done       (o_done)
    );

    pattern_bram u_bram (
        .i_clk     (i_clk),
        .i_wr_enb  (mem_wr_enb),
        .i_wr_addr (i_load_addr),
        .i_wr_data (i_load_data),
        .i_rd_enb  (mem_rd_enb),
        .i_rd_addr (mem_rd_addr),
        .o_rd_data (mem_rd_data)
    );

    axis_producer u_producer (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_restart     (restart),
        .i_run         (run),
        .i_win_start   (win_start),
        .i_win_end     (win_end),
        .o_mem_rd_enb  (mem_rd_enb),
        .o_mem_rd_addr (mem_rd_addr),
        .i_mem_rd_data (mem_rd_data),
        .i_axis_ready  (i_axis_ready),
        .o_axis_valid  (o_axis_valid),
        .o_axis_data   (o_axis_data),
        .o_axis_last   (o_axis_last)
    );

    stream_checksum u_checksum (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_restart    (restart),
        .i_axis_valid (o_axis_valid),
        .i_axis_ready (i_axis_ready),
        .i_axis_data  (o_axis_data),
        .o_checksum   (o_checksum)
    );

endmodule

/* tb/stream_gen_props.sv */
////////////////////
// handshake and control assertions
////////////////////

`timescale 1ns/1ps

module stream_gen_props
    import stream_pkg::*;
(
    input logic  i_clk,
    input logic  i_rst,
    input logic  i_valid,
    input logic  i_ready,
    input data_t i_data,
    input logic  i_last,
    input logic  i_busy,
    input logic  i_done,
    input logic  i_load_ready
);

    // a stalled word keeps its data and last flag until it is taken.
    a_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_valid && !i_ready) |=> (i_valid && $stable(i_data) && $stable(i_last)))
        else $error("stream word changed while stalled");

    a_reset_valid: assert property (@(posedge i_clk) i_rst |=> !i_valid)
        else $error("valid high in the cycle after reset");

    a_done_pulse: assert property (@(posedge i_clk) disable iff (i_rst) i_done |=> !i_done)
        else $error("done held longer than one cycle");

    // a run ends only with a done pulse, and loads are taken again in that cycle.
    a_busy_end: assert property (@(posedge i_clk) disable iff (i_rst)
        $fell(i_busy) |-> (i_done && i_load_ready))
        else $error("busy fell without done and load ready");

endmodule

// the producer carries the stream and the control module carries busy, done and load ready.
bind axis_producer stream_gen_props u_producer_props (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_valid      (o_axis_valid),
    .i_ready      (i_axis_ready),
    .i_data       (o_axis_data),
    .i_last       (o_axis_last),
    .i_busy       (1'b0),
    .i_done       (1'b0),
    .i_load_ready (1'b0)
);

bind stream_ctrl stream_gen_props u_ctrl_props (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_valid      (1'b0),
    .i_ready      (1'b0),
    .i_data       ('0),
    .i_last       (1'b0),
    .i_busy       (o_busy),
    .i_done       (o_done),
    .i_load_ready (o_load_ready)
);

/* tb/stream_gen_tb.sv */
////////////////////
// testbench with run table, memory model,
// ready patterns, compare tasks and watchdog
////////////////////

`timescale 1ns/1ps

module stream_gen_tb
    import stream_pkg::*;
();

    localparam int NROWS = 10;
    localparam logic [1:0] MODE_ALWAYS = 2'd0;
    localparam logic [1:0] MODE_RANDOM = 2'd1;
    localparam logic [1:0] MODE_STALL  = 2'd2;

    typedef struct packed {
        addr_t      start_addr;
        addr_t      end_addr;
        pass_t      passes;
        logic [1:0] mode;
        logic       reject;
        logic       disturb;
    } row_t;

    logic  i_clk;
    logic  i_rst;
    logic  i_load_valid;
    addr_t i_load_addr;
    data_t i_load_data;
    logic  o_load_ready;
    logic  i_start;
    addr_t i_start_addr;
    addr_t i_end_addr;
    pass_t i_pass_count;
    logic  i_axis_ready;
    logic  o_axis_valid;
    data_t o_axis_data;
    logic  o_axis_last;
    logic  o_busy;
    logic  o_done;
    chk_t  o_checksum;

    data_t       model_mem [2**NB_ADDR];
    row_t        rows [NROWS];
    logic [31:0] lcg_state;
    logic [1:0]  ready_mode;
    int          stall_cnt = 0;
    data_t       got_data [$];
    logic        got_last [$];
    data_t       exp_data [$];
    logic        exp_last [$];
    chk_t        model_chk = '0;
    int          done_count = 0;
    int          data_errors = 0;
    int          last_errors = 0;
    int          chk_errors = 0;
    int          flag_errors = 0;
    int          other_errors = 0;
    bit          table_ready = 1'b0;
    int          total_words = 0;

    stream_gen_top dut0 (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_load_valid (i_load_valid),
        .i_load_addr  (i_load_addr),
        .i_load_data  (i_load_data),
        .o_load_ready (o_load_ready),
        .i_start      (i_start),
        .i_start_addr (i_start_addr),
        .i_end_addr   (i_end_addr),
        .i_pass_count (i_pass_count),
        .i_axis_ready (i_axis_ready),
        .o_axis_valid (o_axis_valid),
        .o_axis_data  (o_axis_data),
        .o_axis_last  (o_axis_last),
        .o_busy       (o_busy),
        .o_done       (o_done),
        .o_checksum   (o_checksum)
    );

    initial i_clk = 1'b0;
    always #20 i_clk = ~i_clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic random_bit();
        logic [31:0] v;
        v = lcg_next();
        return v[16];
    endfunction

    // the signature rotates left by one and then takes in the accepted word by xor.
    function automatic chk_t fold_word(chk_t sig, data_t word);
        return ((sig << 1) | (sig >> (NB_DATA-1))) ^ word;
    endfunction

    task automatic check_data(int idx, data_t got, data_t exp);
        if (got !== exp) begin
            data_errors++;
            $display("CHECK FAILED o_axis_data[%0d] got 0x%h expected 0x%h", idx, got, exp);
        end
    endtask

    task automatic check_last(int idx, logic got, logic exp);
        if (got !== exp) begin
            last_errors++;
            $display("CHECK FAILED o_axis_last[%0d] got 0x%h expected 0x%h", idx, got, exp);
        end
    endtask

    task automatic check_checksum(chk_t got, chk_t exp);
        if (got !== exp) begin
            chk_errors++;
            $display("CHECK FAILED o_checksum got 0x%h expected 0x%h", got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // long stalls hold ready low for 8 cycles and high for 4.
    always @(posedge i_clk) begin
        stall_cnt <= (stall_cnt == 11) ? 0 : stall_cnt + 1;
        case (ready_mode)
            MODE_RANDOM: i_axis_ready <= random_bit();
            MODE_STALL:  i_axis_ready <= (stall_cnt >= 8);
            default:     i_axis_ready <= 1'b1;
        endcase
    end

    // a transfer seen here completes at the next rising edge.
    always @(negedge i_clk) begin
        if (!i_rst) begin
            if (o_axis_valid && i_axis_ready) begin
                got_data.push_back(o_axis_data);
                got_last.push_back(o_axis_last);
            end
            if (o_done) begin
                done_count++;
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat (total_words * 40 + 2000) @(posedge i_clk);
        $display("watchdog expired, the run did not finish %0d words in time", total_words);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic build_table();
        int i;
        rows[0] = '{6'd4,  6'd11, 8'd2, MODE_ALWAYS, 1'b0, 1'b0};
        rows[1] = '{6'd0,  6'd63, 8'd1, MODE_ALWAYS, 1'b0, 1'b0};
        rows[2] = '{6'd10, 6'd20, 8'd3, MODE_RANDOM, 1'b0, 1'b0};
        rows[3] = '{6'd30, 6'd37, 8'd2, MODE_STALL,  1'b0, 1'b0};
        rows[4] = '{6'd5,  6'd5,  8'd4, MODE_RANDOM, 1'b0, 1'b0};
        rows[5] = '{6'd40, 6'd50, 8'd2, MODE_STALL,  1'b0, 1'b1};
        rows[6] = '{6'd20, 6'd10, 8'd2, MODE_ALWAYS, 1'b1, 1'b0};
        rows[7] = '{6'd8,  6'd15, 8'd0, MODE_ALWAYS, 1'b0, 1'b0};
        rows[8] = '{6'd40, 6'd42, 8'd3, MODE_ALWAYS, 1'b0, 1'b0};
        rows[9] = '{6'd60, 6'd63, 8'd2, MODE_RANDOM, 1'b0, 1'b0};
        for (i = 0; i < NROWS; i++) begin
            if (!rows[i].reject) begin
                total_words += (int'(rows[i].end_addr) - int'(rows[i].start_addr) + 1)
                               * int'(rows[i].passes);
            end
        end
        table_ready = 1'b1;
    endtask

    task automatic load_memory();
        int a;
        for (a = 0; a < 2**NB_ADDR; a++) begin
            model_mem[a] = lcg_next() ^ (32'(a) << 26);
        end
        for (a = 0; a < 2**NB_ADDR; a++) begin
            @(posedge i_clk);
            i_load_valid <= 1'b1;
            i_load_addr  <= addr_t'(a);
            i_load_data  <= model_mem[a];
            @(negedge i_clk);
            check_flag("o_load_ready", o_load_ready, 1'b1);
        end
        @(posedge i_clk);
        i_load_valid <= 1'b0;
    endtask

    // a second start and a load while the run is busy must both be ignored.
    task automatic disturb_run(addr_t addr);
        @(negedge i_clk);
        check_flag("o_busy", o_busy, 1'b1);
        @(posedge i_clk);
        i_start      <= 1'b1;
        i_start_addr <= '0;
        i_end_addr   <= addr_t'(3);
        i_pass_count <= pass_t'(1);
        i_load_valid <= 1'b1;
        i_load_addr  <= addr;
        i_load_data  <= ~model_mem[addr];
        @(negedge i_clk);
        check_flag("o_load_ready", o_load_ready, 1'b0);
        @(posedge i_clk);
        i_start      <= 1'b0;
        i_load_valid <= 1'b0;
    endtask

    task automatic wait_done(int base, int limit, int r);
        int waited;
        waited = 0;
        while (done_count == base && waited < limit) begin
            @(posedge i_clk);
            waited++;
        end
        if (done_count == base) begin
            other_errors++;
            $display("row %0d: no done pulse within %0d cycles", r, limit);
        end
    endtask

    task automatic run_row(int r);
        row_t row;
        int   base;
        int   p;
        int   a;
        int   i;
        chk_t exp_chk;
        row = rows[r];
        @(negedge i_clk);
        ready_mode = row.mode;
        exp_chk    = model_chk;
        exp_data.delete();
        exp_last.delete();
        if (!row.reject) begin
            exp_chk = '0;
            for (p = 0; p < int'(row.passes); p++) begin
                for (a = int'(row.start_addr); a <= int'(row.end_addr); a++) begin
                    exp_data.push_back(model_mem[a]);
                    exp_last.push_back(a == int'(row.end_addr));
                    exp_chk = fold_word(exp_chk, model_mem[a]);
                end
            end
        end
        @(posedge i_clk);
        got_data.delete();
        got_last.delete();
        base = done_count;
        i_start      <= 1'b1;
        i_start_addr <= row.start_addr;
        i_end_addr   <= row.end_addr;
        i_pass_count <= row.passes;
        @(posedge i_clk);
        i_start <= 1'b0;
        if (row.disturb) begin
            disturb_run(row.start_addr);
        end
        if (!row.reject) begin
            wait_done(base, exp_data.size() * 40 + 200, r);
        end
        repeat (8) begin
            @(negedge i_clk);
            check_flag("o_busy", o_busy, 1'b0);
            check_flag("o_axis_valid", o_axis_valid, 1'b0);
        end
        check_checksum(o_checksum, exp_chk);
        model_chk = exp_chk;
        @(posedge i_clk);
        if (done_count != base + (row.reject ? 0 : 1)) begin
            other_errors++;
            $display("row %0d: saw %0d done pulses", r, done_count - base);
        end
        if (got_data.size() != exp_data.size()) begin
            other_errors++;
            $display("row %0d: received %0d words, expected %0d",
                     r, got_data.size(), exp_data.size());
        end
        for (i = 0; i < exp_data.size() && i < got_data.size(); i++) begin
            check_data(i, got_data[i], exp_data[i]);
            check_last(i, got_last[i], exp_last[i]);
        end
    endtask

    initial begin
        int r;
        int errors;
        i_rst        = 1'b1;
        i_load_valid = 1'b0;
        i_load_addr  = '0;
        i_load_data  = '0;
        i_start      = 1'b0;
        i_start_addr = '0;
        i_end_addr   = '0;
        i_pass_count = '0;
        i_axis_ready = 1'b1;
        ready_mode   = MODE_ALWAYS;
        lcg_state    = 32'h35b3;
        build_table();
        repeat (10) @(posedge i_clk);
        i_rst <= 1'b0;
        @(negedge i_clk);
        check_flag("o_axis_valid", o_axis_valid, 1'b0);
        check_flag("o_busy", o_busy, 1'b0);
        check_flag("o_done", o_done, 1'b0);
        check_flag("o_load_ready", o_load_ready, 1'b1);
        check_checksum(o_checksum, '0);
        load_memory();
        for (r = 0; r < NROWS; r++) begin
            run_row(r);
        end
        errors = data_errors + last_errors + chk_errors + flag_errors + other_errors;
        $display("errors: %0d total, data %0d, last %0d, checksum %0d, flag %0d, other %0d",
                 errors, data_errors, last_errors, chk_errors, flag_errors, other_errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end
        else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
common/stream_pkg.sv
logic/pattern_bram.sv
producer/axis_producer.sv
logic/stream_ctrl.sv
logic/stream_checksum.sv
logic/stream_gen_top.sv
tb/stream_gen_props.sv
tb/stream_gen_tb.sv
